/* common/fpc_config.svh */
`ifndef FPC_CONFIG_SVH
`define FPC_CONFIG_SVH

// number of tasks that both cores run in lockstep
`define FPC_TASKS 16
`define FPC_TASK_W 4

// each task owns this many entries in every core's bank
`define FPC_REGION_DEPTH 8

// RAM address width, which covers FPC_TASKS regions of FPC_REGION_DEPTH entries
`define FPC_PTR_W 7

// width of one CRC fingerprint
`define FPC_FPRINT_W 16

`endif

/* common/fpc_pkg.sv */
`default_nettype none

`include "fpc_config.svh"

package fpc_pkg;

	// address into one core's fingerprint bank
	typedef logic [`FPC_PTR_W-1:0] fpc_ptr_t;

	// one checkpoint fingerprint sent by a core
	typedef struct packed {
		logic                     core;
		logic [`FPC_TASK_W-1:0]   task_id;
		logic [`FPC_FPRINT_W-1:0] fprint;
	} fpc_submit_t;

	// moves the heads and tails of one task, for both cores at once
	typedef struct packed {
		logic [`FPC_TASK_W-1:0] task_id;
		fpc_ptr_t               ptr;
	} fpc_cfg_t;

	// outcome of comparing the oldest pending pair of a task
	typedef struct packed {
		logic [`FPC_TASK_W-1:0]   task_id;
		logic                     match;
		logic [`FPC_FPRINT_W-1:0] fprint0;
		logic [`FPC_FPRINT_W-1:0] fprint1;
	} fpc_result_t;

endpackage

`default_nettype wire

/* logic/fprint_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpc_config.svh"

module fprint_ram (
	input  wire logic                     clk,
	input  wire logic                     wr_en,
	input  wire logic                     wr_core,
	input  wire fpc_pkg::fpc_ptr_t        wr_addr,
	input  wire logic [`FPC_FPRINT_W-1:0] wr_data,
	input  wire fpc_pkg::fpc_ptr_t        rd_addr0,
	input  wire fpc_pkg::fpc_ptr_t        rd_addr1,
	output logic [`FPC_FPRINT_W-1:0]      rd_data0,
	output logic [`FPC_FPRINT_W-1:0]      rd_data1
);

	localparam int WORDS = 1 << `FPC_PTR_W;

	// bank 0 holds core 0's fingerprints and bank 1 core 1's
	logic [`FPC_FPRINT_W-1:0] mem [2][WORDS];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_core][wr_addr] <= wr_data;
		rd_data0 <= mem[0][rd_addr0]; // both banks are read every cycle
		rd_data1 <= mem[1][rd_addr1];
	end

endmodule

`default_nettype wire

/* logic/fprint_capture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpc_config.svh"

module fprint_capture (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire logic                   sub_req,
	output logic                        sub_ack,
	input  wire fpc_pkg::fpc_submit_t   sub_data,
	output logic                        core_id,
	output logic [`FPC_TASK_W-1:0]      task_id,
	input  wire fpc_pkg::fpc_ptr_t      head_pointer,
	output logic                        inc_req,
	input  wire logic                   inc_ack,
	output logic                        wr_en,
	output logic                        wr_core,
	output fpc_pkg::fpc_ptr_t           wr_addr,
	output logic [`FPC_FPRINT_W-1:0]    wr_data
);
	import fpc_pkg::*;

	typedef enum logic [2:0] {
		CAP_IDLE,
		CAP_LOOKUP,
		CAP_WRITE,
		CAP_INC,
		CAP_ACK
	} cap_state_t;

	cap_state_t  state;
	fpc_submit_t sub_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= CAP_IDLE;
		end else begin
			case (state)
				CAP_IDLE: begin
					if (sub_req)
						state <= CAP_LOOKUP;
				end
				CAP_LOOKUP: state <= CAP_WRITE; // head pointer read is registered
				CAP_WRITE:  state <= CAP_INC;
				CAP_INC: begin
					if (inc_ack)
						state <= CAP_ACK;
				end
				CAP_ACK: begin
					if (!sub_req)
						state <= CAP_IDLE; // ack drops once the sender has let go
				end
				default:    state <= CAP_IDLE;
			endcase
		end
	end

	// the sender keeps sub_data stable, but a copy frees the port early
	always_ff @(posedge clk) begin
		if (state == CAP_IDLE && sub_req)
			sub_q <= sub_data;
	end

	assign core_id = sub_q.core;
	assign task_id = sub_q.task_id;

	assign wr_en   = (state == CAP_WRITE);
	assign wr_core = sub_q.core;
	assign wr_addr = head_pointer;
	assign wr_data = sub_q.fprint;

	assign inc_req = (state == CAP_INC); // held until comp_registers acknowledges
	assign sub_ack = (state == CAP_ACK);

endmodule

`default_nettype wire

/* comp_registers/comp_registers.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpc_config.svh"

module comp_registers (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire fpc_pkg::fpc_ptr_t      head_tail_data,
	input  wire logic [`FPC_TASK_W-1:0] head_tail_offset,
	input  wire logic                   set_head_tail,
	output logic                        head_tail_ack,
	input  wire logic                   logical_core_id,
	input  wire logic [`FPC_TASK_W-1:0] fprint_task_id,
	output fpc_pkg::fpc_ptr_t           fprint_head_pointer,
	input  wire logic                   increment_head_pointer,
	output logic                        increment_hp_ack,
	input  wire logic [`FPC_TASK_W-1:0] comp_task,
	output logic [`FPC_TASKS-1:0]       fprints_ready_out,
	output logic                        head0_matches_head1,
	output logic                        tail0_matches_head0,
	output logic                        tail1_matches_head1,
	output fpc_pkg::fpc_ptr_t           comp_tail_pointer0,
	output fpc_pkg::fpc_ptr_t           comp_tail_pointer1,
	input  wire logic                   comp_increment_tail_pointer,
	input  wire logic                   comp_reset_fprint_ready,
	input  wire logic                   comp_mismatch_detected,
	output logic                        reset_fprint_ack
);
	import fpc_pkg::*;

	localparam fpc_ptr_t DEPTH    = fpc_ptr_t'(`FPC_REGION_DEPTH);
	localparam fpc_ptr_t LAST_OFS = fpc_ptr_t'(`FPC_REGION_DEPTH - 1);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SET,
		ST_SET_ACK,
		ST_INC_ACK,
		ST_CLR_ACK
	} state_t;

	state_t state;

	fpc_ptr_t head_mem [2][`FPC_TASKS]; // indexed by core, then task
	fpc_ptr_t tail_mem [2][`FPC_TASKS];

	fpc_ptr_t fprint_hp [2]; // head of the task that capture is working on
	fpc_ptr_t comp_hp [2];   // head and tail of the task under comparison
	fpc_ptr_t comp_tp [2];

	logic [`FPC_TASKS-1:0] ready_core [2];
	logic [1:0]            core_drained;
	logic                  flush;

	function automatic fpc_ptr_t region_start(input logic [`FPC_TASK_W-1:0] t);
		region_start = fpc_ptr_t'(t) * DEPTH;
	endfunction

	// the last entry of a region wraps back to its first one
	function automatic fpc_ptr_t next_ptr(input fpc_ptr_t p, input logic [`FPC_TASK_W-1:0] t);
		fpc_ptr_t start;
		start = region_start(t);
		if (p == start + LAST_OFS)
			next_ptr = start;
		else
			next_ptr = p + fpc_ptr_t'(1);
	endfunction

	// one request is served at a time, configuration first and ready clearing last
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (set_head_tail)
						state <= ST_SET;
					else if (increment_head_pointer)
						state <= ST_INC_ACK;
					else if (comp_reset_fprint_ready)
						state <= ST_CLR_ACK;
				end
				ST_SET:     state <= ST_SET_ACK;
				default:    state <= ST_IDLE; // every ack state lasts one cycle
			endcase
		end
	end

	assign head_tail_ack    = (state == ST_SET_ACK);
	assign increment_hp_ack = (state == ST_INC_ACK);
	assign reset_fprint_ack = (state == ST_CLR_ACK);
	assign flush            = reset_fprint_ack && comp_mismatch_detected;

	always_ff @(posedge clk) begin
		for (int c = 0; c < 2; c++) begin
			if (state == ST_SET) begin
				head_mem[c][head_tail_offset] <= head_tail_data;
			end else if (state == ST_INC_ACK) begin
				if (logical_core_id == c[0])
					head_mem[c][fprint_task_id] <= next_ptr(fprint_hp[c], fprint_task_id);
			end else if (flush) begin
				head_mem[c][comp_task] <= region_start(comp_task);
			end
			fprint_hp[c] <= head_mem[c][fprint_task_id];
			comp_hp[c]   <= head_mem[c][comp_task];
		end
	end

	always_ff @(posedge clk) begin
		for (int c = 0; c < 2; c++) begin
			if (state == ST_SET)
				tail_mem[c][head_tail_offset] <= head_tail_data;
			else if (comp_increment_tail_pointer)
				tail_mem[c][comp_task] <= next_ptr(comp_tp[c], comp_task);
			else if (flush)
				tail_mem[c][comp_task] <= region_start(comp_task);
			comp_tp[c] <= tail_mem[c][comp_task];
		end
	end

	// live view of the arrays, so a head that moved just before the clear keeps its flag
	always_comb begin
		for (int c = 0; c < 2; c++) begin
			core_drained[c] = (tail_mem[c][comp_task] == head_mem[c][comp_task]);
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ready_core[0] <= '0;
			ready_core[1] <= '0;
		end else begin
			for (int c = 0; c < 2; c++) begin
				if (state == ST_SET) begin
					ready_core[c][head_tail_offset] <= 1'b0; // moved pointers leave nothing pending
				end else if (state == ST_INC_ACK) begin
					if (logical_core_id == c[0])
						ready_core[c][fprint_task_id] <= 1'b1;
				end else if (state == ST_CLR_ACK) begin
					if (comp_mismatch_detected || core_drained[c])
						ready_core[c][comp_task] <= 1'b0;
				end
			end
		end
	end

	assign fprints_ready_out   = ready_core[0] & ready_core[1];
	assign fprint_head_pointer = fprint_hp[logical_core_id];

	assign comp_tail_pointer0  = comp_tp[0];
	assign comp_tail_pointer1  = comp_tp[1];
	assign head0_matches_head1 = (comp_hp[0] == comp_hp[1]);
	assign tail0_matches_head0 = (comp_tp[0] == comp_hp[0]);
	assign tail1_matches_head1 = (comp_tp[1] == comp_hp[1]);

endmodule

`default_nettype wire

/* logic/fprint_comparator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpc_config.svh"

module fprint_comparator (
	input  wire logic                     clk,
	input  wire logic                     reset,
	input  wire logic [`FPC_TASKS-1:0]    ready_tasks,
	output logic [`FPC_TASK_W-1:0]        comp_task,
	input  wire fpc_pkg::fpc_ptr_t        tail0,
	input  wire fpc_pkg::fpc_ptr_t        tail1,
	input  wire logic                     tail0_at_head,
	input  wire logic                     tail1_at_head,
	output fpc_pkg::fpc_ptr_t             rd_addr0,
	output fpc_pkg::fpc_ptr_t             rd_addr1,
	input  wire logic [`FPC_FPRINT_W-1:0] rd_data0,
	input  wire logic [`FPC_FPRINT_W-1:0] rd_data1,
	output logic                          inc_tail,
	output logic                          clr_req,
	output logic                          mismatch,
	input  wire logic                     clr_ack,
	output logic                          res_req,
	input  wire logic                     res_ack,
	output fpc_pkg::fpc_result_t          res_data
);

	typedef enum logic [3:0] {
		CMP_IDLE,
		CMP_PTR,
		CMP_READ,
		CMP_EVAL,
		CMP_RESP,
		CMP_DONE,
		CMP_INC,
		CMP_SETTLE,
		CMP_CHECK,
		CMP_CLR
	} cmp_state_t;

	cmp_state_t             state;
	logic [`FPC_TASK_W-1:0] pick;

	// lowest numbered ready task wins
	always_comb begin
		pick = '0;
		for (int i = `FPC_TASKS - 1; i >= 0; i--) begin
			if (ready_tasks[i])
				pick = i[`FPC_TASK_W-1:0];
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state     <= CMP_IDLE;
			comp_task <= '0;
		end else begin
			case (state)
				CMP_IDLE: begin
					if (|ready_tasks) begin
						comp_task <= pick;
						state     <= CMP_PTR;
					end
				end
				CMP_PTR:    state <= CMP_READ; // tails of the new task arrive after one cycle
				CMP_READ:   state <= CMP_EVAL; // RAM output is registered
				CMP_EVAL:   state <= CMP_RESP;
				CMP_RESP: begin
					if (res_ack)
						state <= CMP_DONE;
				end
				CMP_DONE: begin
					if (!res_ack)
						state <= res_data.match ? CMP_INC : CMP_CLR;
				end
				CMP_INC:    state <= CMP_SETTLE;
				CMP_SETTLE: state <= CMP_CHECK; // lets the advanced tails reach the flags
				CMP_CHECK: begin
					if (tail0_at_head || tail1_at_head)
						state <= CMP_CLR;
					else
						state <= CMP_IDLE;
				end
				CMP_CLR: begin
					if (clr_ack)
						state <= CMP_IDLE;
				end
				default:    state <= CMP_IDLE;
			endcase
		end
	end

	// result is frozen from EVAL until the next pair, so it stays stable during the handshake
	always_ff @(posedge clk) begin
		if (state == CMP_EVAL) begin
			res_data.task_id <= comp_task;
			res_data.match   <= (rd_data0 == rd_data1);
			res_data.fprint0 <= rd_data0;
			res_data.fprint1 <= rd_data1;
		end
	end

	assign rd_addr0 = tail0;
	assign rd_addr1 = tail1;

	assign res_req  = (state == CMP_RESP);
	assign inc_tail = (state == CMP_INC);
	assign clr_req  = (state == CMP_CLR);
	assign mismatch = (state == CMP_CLR) && !res_data.match; // a mismatch turns the clear into a flush

endmodule

`default_nettype wire

/* logic/fpc_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpc_config.svh"

module fpc_top (
	input  wire logic                 clk,
	input  wire logic                 reset,
	input  wire logic                 sub_req,
	output logic                      sub_ack,
	input  wire fpc_pkg::fpc_submit_t sub_data,
	input  wire logic                 cfg_req,
	output logic                      cfg_ack,
	input  wire fpc_pkg::fpc_cfg_t    cfg_data,
	output logic                      res_req,
	input  wire logic                 res_ack,
	output fpc_pkg::fpc_result_t      res_data
);
	import fpc_pkg::*;

	logic                     core_id;
	logic [`FPC_TASK_W-1:0]   task_id;
	fpc_ptr_t                 head_ptr;
	logic                     inc_req;
	logic                     inc_ack;
	logic                     wr_en;
	logic                     wr_core;
	fpc_ptr_t                 wr_addr;
	logic [`FPC_FPRINT_W-1:0] wr_data;

	logic [`FPC_TASK_W-1:0]   comp_task;
	logic [`FPC_TASKS-1:0]    ready_tasks;
	fpc_ptr_t                 tail0;
	fpc_ptr_t                 tail1;
	logic                     tail0_at_head;
	logic                     tail1_at_head;
	fpc_ptr_t                 rd_addr0;
	fpc_ptr_t                 rd_addr1;
	logic [`FPC_FPRINT_W-1:0] rd_data0;
	logic [`FPC_FPRINT_W-1:0] rd_data1;
	logic                     inc_tail;
	logic                     clr_req;
	logic                     mismatch;
	logic                     clr_ack;

	logic                     set_head_tail;
	logic                     head_tail_ack;

	// cfg_ack rises on the one-cycle ack and falls after the sender drops cfg_req
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			cfg_ack <= 1'b0;
		else if (head_tail_ack)
			cfg_ack <= 1'b1;
		else if (!cfg_req)
			cfg_ack <= 1'b0;
	end

	assign set_head_tail = cfg_req && !cfg_ack;

	fprint_capture u_capture (
		.clk          (clk),
		.reset        (reset),
		.sub_req      (sub_req),
		.sub_ack      (sub_ack),
		.sub_data     (sub_data),
		.core_id      (core_id),
		.task_id      (task_id),
		.head_pointer (head_ptr),
		.inc_req      (inc_req),
		.inc_ack      (inc_ack),
		.wr_en        (wr_en),
		.wr_core      (wr_core),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data)
	);

	comp_registers u_regs (
		.clk                         (clk),
		.reset                       (reset),
		.head_tail_data              (cfg_data.ptr),
		.head_tail_offset            (cfg_data.task_id),
		.set_head_tail               (set_head_tail),
		.head_tail_ack               (head_tail_ack),
		.logical_core_id             (core_id),
		.fprint_task_id              (task_id),
		.fprint_head_pointer         (head_ptr),
		.increment_head_pointer      (inc_req),
		.increment_hp_ack            (inc_ack),
		.comp_task                   (comp_task),
		.fprints_ready_out           (ready_tasks),
		.head0_matches_head1         (),
		.tail0_matches_head0         (tail0_at_head),
		.tail1_matches_head1         (tail1_at_head),
		.comp_tail_pointer0          (tail0),
		.comp_tail_pointer1          (tail1),
		.comp_increment_tail_pointer (inc_tail),
		.comp_reset_fprint_ready     (clr_req),
		.comp_mismatch_detected      (mismatch),
		.reset_fprint_ack            (clr_ack)
	);

	fprint_ram u_ram (
		.clk      (clk),
		.wr_en    (wr_en),
		.wr_core  (wr_core),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.rd_addr0 (rd_addr0),
		.rd_addr1 (rd_addr1),
		.rd_data0 (rd_data0),
		.rd_data1 (rd_data1)
	);

	fprint_comparator u_comparator (
		.clk           (clk),
		.reset         (reset),
		.ready_tasks   (ready_tasks),
		.comp_task     (comp_task),
		.tail0         (tail0),
		.tail1         (tail1),
		.tail0_at_head (tail0_at_head),
		.tail1_at_head (tail1_at_head),
		.rd_addr0      (rd_addr0),
		.rd_addr1      (rd_addr1),
		.rd_data0      (rd_data0),
		.rd_data1      (rd_data1),
		.inc_tail      (inc_tail),
		.clr_req       (clr_req),
		.mismatch      (mismatch),
		.clr_ack       (clr_ack),
		.res_req       (res_req),
		.res_ack       (res_ack),
		.res_data      (res_data)
	);

endmodule

`default_nettype wire

/* verification/fpc_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module fpc_assertions (
	input wire logic                 clk,
	input wire logic                 reset,
	input wire logic                 sub_req,
	input wire logic                 sub_ack,
	input wire logic                 res_req,
	input wire logic                 res_ack,
	input wire fpc_pkg::fpc_result_t res_data
);

	int unsigned failures = 0; // read by the testbench at the end of the run

	// the ack rose on the previous edge, where the request must still have been up
	sub_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(sub_ack) |-> $past(sub_req))
		else begin
			failures++;
			$error("sub_ack rose while sub_req was low");
		end

	res_data_stable: assert property (@(posedge clk) disable iff (reset)
		(res_req && !res_ack) |=> $stable(res_data))
		else begin
			failures++;
			$error("res_data changed while waiting for res_ack");
		end

	res_req_held: assert property (@(posedge clk) disable iff (reset)
		(res_req && !res_ack) |=> res_req)
		else begin
			failures++;
			$error("res_req dropped before res_ack rose");
		end

endmodule

bind fpc_top fpc_assertions u_assertions (
	.clk      (clk),
	.reset    (reset),
	.sub_req  (sub_req),
	.sub_ack  (sub_ack),
	.res_req  (res_req),
	.res_ack  (res_ack),
	.res_data (res_data)
);

`default_nettype wire

/* verification/fpc_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpc_config.svh"

module fpc_checker (
	input  wire logic                 clk,
	input  wire logic                 reset,
	input  wire logic                 sub_ack,
	input  wire fpc_pkg::fpc_submit_t sub_data,
	input  wire logic                 res_req,
	input  wire logic                 res_ack,
	input  wire fpc_pkg::fpc_result_t res_data,
	input  wire logic                 test_end,
	input  wire logic [3:0]           test_id,
	input  wire logic [31:0]          test_results,
	output int unsigned               result_count,
	output int unsigned               error_count,
	output int unsigned               pending
);
	import fpc_pkg::*;

	logic [`FPC_FPRINT_W-1:0] fq [2*`FPC_TASKS][$]; // one queue per task and core, task*2+core
	fpc_result_t              exp_q [`FPC_TASKS][$];
	logic                     sub_ack_q;
	logic                     res_ack_q;
	int unsigned              results_before;
	int unsigned              errors_before;

	// a new fingerprint pairs with the oldest one of the other core
	task automatic push_submission(input fpc_submit_t s);
		int          base;
		fpc_result_t e;
		base = 2 * int'(s.task_id);
		fq[base + int'(s.core)].push_back(s.fprint);
		if (fq[base].size() > 0 && fq[base + 1].size() > 0) begin
			e.task_id = s.task_id;
			e.fprint0 = fq[base].pop_front();
			e.fprint1 = fq[base + 1].pop_front();
			e.match   = (e.fprint0 == e.fprint1);
			exp_q[s.task_id].push_back(e);
			pending++;
			if (!e.match) begin
				fq[base].delete(); // the flush throws away what is still queued on the task
				fq[base + 1].delete();
			end
		end
	endtask

	task automatic check_result(input fpc_result_t r);
		fpc_result_t e;
		result_count++;
		if (exp_q[r.task_id].size() == 0) begin
			$display("[FAIL] %0t: result for task %0d with no pair pending", $time, r.task_id);
			error_count++;
		end else begin
			e = exp_q[r.task_id].pop_front();
			pending--;
			if (r !== e) begin
				$display("[FAIL] %0t: task %0d gave match=%0b %h/%h, expected match=%0b %h/%h",
					$time, r.task_id, r.match, r.fprint0, r.fprint1, e.match, e.fprint0,
					e.fprint1);
				error_count++;
			end
		end
	endtask

	task automatic close_test;
		if (pending != 0) begin
			$display("[FAIL] %0t: test %0d ended with %0d results missing", $time, test_id,
				pending);
			error_count++;
		end
		if (result_count != test_results) begin
			$display("[FAIL] %0t: test %0d saw %0d results in total, expected %0d", $time,
				test_id, result_count, test_results);
			error_count++;
		end
		$display("test %0d finished: %0d results, %0d errors", test_id,
			result_count - results_before, error_count - errors_before);
		results_before = result_count;
		errors_before  = error_count;
	endtask

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			sub_ack_q      = 1'b0;
			res_ack_q      = 1'b0;
			result_count   = 0;
			error_count    = 0;
			pending        = 0;
			results_before = 0;
			errors_before  = 0;
		end else begin
			if (sub_ack && !sub_ack_q)
				push_submission(sub_data); // sub_data is still held by the sender here
			if (res_req && res_ack && !res_ack_q)
				check_result(res_data);
			if (test_end)
				close_test();
			sub_ack_q = sub_ack;
			res_ack_q = res_ack;
		end
	end

endmodule

`default_nettype wire

/* verification/fpc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpc_config.svh"

module fpc_tb;
	import fpc_pkg::*;

	localparam int SETTLE_CYCLES = 8; // a flush lands a few cycles after its result handshake

	typedef enum logic [1:0] {
		K_CFG,
		K_SUB,
		K_DRAIN
	} kind_t;

	// results holds the running total of results expected once a drain row is done
	typedef struct packed {
		kind_t                    kind;
		logic [3:0]               test;
		logic                     core;
		logic [`FPC_TASK_W-1:0]   task_id;
		fpc_ptr_t                 ptr;
		logic [`FPC_FPRINT_W-1:0] fprint;
		logic [7:0]               results;
	} row_t;

	logic        clk;
	logic        reset;
	logic        sub_req;
	logic        sub_ack;
	fpc_submit_t sub_data;
	logic        cfg_req;
	logic        cfg_ack;
	fpc_cfg_t    cfg_data;
	logic        res_req;
	logic        res_ack;
	fpc_result_t res_data;

	logic        test_end;
	logic [3:0]  test_id;
	int unsigned test_results;
	int unsigned result_count;
	int unsigned error_count;
	int unsigned pending;

	row_t   rows [$];
	int     timeout_limit = 0;
	int     cycle_count = 0;
	integer seed;
	int     wait_cycles;

	fpc_top DUT (
		.clk      (clk),
		.reset    (reset),
		.sub_req  (sub_req),
		.sub_ack  (sub_ack),
		.sub_data (sub_data),
		.cfg_req  (cfg_req),
		.cfg_ack  (cfg_ack),
		.cfg_data (cfg_data),
		.res_req  (res_req),
		.res_ack  (res_ack),
		.res_data (res_data)
	);

	fpc_checker u_checker (
		.clk          (clk),
		.reset        (reset),
		.sub_ack      (sub_ack),
		.sub_data     (sub_data),
		.res_req      (res_req),
		.res_ack      (res_ack),
		.res_data     (res_data),
		.test_end     (test_end),
		.test_id      (test_id),
		.test_results (test_results),
		.result_count (result_count),
		.error_count  (error_count),
		.pending      (pending)
	);

	always #20 clk = ~clk;

	function automatic void add_row(kind_t k, int test, int core, int t, int p, int fp, int res);
		row_t r;
		r.kind    = k;
		r.test    = test[3:0];
		r.core    = core[0];
		r.task_id = t[`FPC_TASK_W-1:0];
		r.ptr     = p[`FPC_PTR_W-1:0];
		r.fprint  = fp[`FPC_FPRINT_W-1:0];
		r.results = res[7:0];
		rows.push_back(r);
	endfunction

	function automatic void load_table;
		add_row(K_CFG,   1, 0, 0, 0, 'h0000, 0); // a single matching pair
		add_row(K_SUB,   1, 0, 0, 0, 'h1a2b, 0);
		add_row(K_SUB,   1, 1, 0, 0, 'h1a2b, 0);
		add_row(K_DRAIN, 1, 0, 0, 0, 'h0000, 1);
		add_row(K_CFG,   2, 0, 3, 24, 'h0000, 0); // mismatch, then a fresh pair after the flush
		add_row(K_SUB,   2, 0, 3, 0, 'h5555, 0);
		add_row(K_SUB,   2, 0, 3, 0, 'h6666, 0);
		add_row(K_SUB,   2, 1, 3, 0, 'h5554, 0);
		add_row(K_DRAIN, 2, 0, 0, 0, 'h0000, 2);
		add_row(K_SUB,   2, 0, 3, 0, 'h7777, 0);
		add_row(K_SUB,   2, 1, 3, 0, 'h7777, 0);
		add_row(K_DRAIN, 2, 0, 0, 0, 'h0000, 3);
		add_row(K_CFG,   3, 0, 2, 16, 'h0000, 0); // core 0 runs four checkpoints ahead
		add_row(K_SUB,   3, 0, 2, 0, 'h3001, 0);
		add_row(K_SUB,   3, 0, 2, 0, 'h3002, 0);
		add_row(K_SUB,   3, 0, 2, 0, 'h3003, 0);
		add_row(K_SUB,   3, 0, 2, 0, 'h3004, 0);
		add_row(K_SUB,   3, 1, 2, 0, 'h3001, 0);
		add_row(K_SUB,   3, 1, 2, 0, 'h3002, 0);
		add_row(K_SUB,   3, 1, 2, 0, 'h3003, 0);
		add_row(K_SUB,   3, 1, 2, 0, 'h3004, 0);
		add_row(K_DRAIN, 3, 0, 0, 0, 'h0000, 7);
		add_row(K_CFG,   4, 0, 6, 48, 'h0000, 0); // the next region, which a missed wrap overwrites
		add_row(K_SUB,   4, 0, 6, 0, 'h6a01, 0);
		add_row(K_SUB,   4, 0, 6, 0, 'h6a02, 0);
		add_row(K_CFG,   4, 0, 5, 47, 'h0000, 0); // starts on the last entry of the region
		add_row(K_SUB,   4, 0, 5, 0, 'h4a01, 0);
		add_row(K_SUB,   4, 1, 5, 0, 'h4a01, 0);
		add_row(K_SUB,   4, 0, 5, 0, 'h4a02, 0);
		add_row(K_SUB,   4, 1, 5, 0, 'h4a02, 0);
		add_row(K_SUB,   4, 0, 5, 0, 'h4a03, 0);
		add_row(K_SUB,   4, 1, 5, 0, 'h4a03, 0);
		add_row(K_SUB,   4, 1, 6, 0, 'h6a01, 0);
		add_row(K_SUB,   4, 1, 6, 0, 'h6a02, 0);
		add_row(K_DRAIN, 4, 0, 0, 0, 'h0000, 12);
		add_row(K_CFG,   5, 0, 7, 56, 'h0000, 0); // three tasks interleaved
		add_row(K_CFG,   5, 0, 9, 72, 'h0000, 0);
		add_row(K_CFG,   5, 0, 12, 96, 'h0000, 0);
		add_row(K_SUB,   5, 0, 7, 0, 'h7001, 0);
		add_row(K_SUB,   5, 0, 9, 0, 'h9001, 0);
		add_row(K_SUB,   5, 1, 12, 0, 'hc001, 0);
		add_row(K_SUB,   5, 1, 7, 0, 'h7001, 0);
		add_row(K_SUB,   5, 0, 12, 0, 'hc001, 0);
		add_row(K_SUB,   5, 1, 9, 0, 'h9001, 0);
		add_row(K_SUB,   5, 0, 7, 0, 'h7002, 0);
		add_row(K_SUB,   5, 1, 9, 0, 'h9002, 0);
		add_row(K_SUB,   5, 0, 9, 0, 'h9002, 0);
		add_row(K_SUB,   5, 1, 7, 0, 'h7002, 0);
		add_row(K_SUB,   5, 0, 12, 0, 'hc002, 0);
		add_row(K_SUB,   5, 1, 12, 0, 'hc0f2, 0);
		add_row(K_DRAIN, 5, 0, 0, 0, 'h0000, 18);
	endfunction

	// all drivers start and end on a falling edge
	task automatic send_submit(input row_t r);
		sub_data.core    = r.core;
		sub_data.task_id = r.task_id;
		sub_data.fprint  = r.fprint;
		sub_req = 1'b1;
		do @(negedge clk); while (!sub_ack);
		sub_req = 1'b0;
		while (sub_ack) @(negedge clk);
	endtask

	task automatic send_cfg(input row_t r);
		cfg_data.task_id = r.task_id;
		cfg_data.ptr     = r.ptr;
		cfg_req = 1'b1;
		do @(negedge clk); while (!cfg_ack);
		cfg_req = 1'b0;
		while (cfg_ack) @(negedge clk);
	endtask

	task automatic drain_results;
		while (pending != 0 || res_req || res_ack) @(negedge clk);
		repeat (SETTLE_CYCLES) @(negedge clk);
	endtask

	task automatic finish_test(input row_t r);
		test_id      = r.test;
		test_results = r.results;
		test_end     = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
	endtask

	// result port back-pressure of 0 to 4 cycles
	initial begin
		seed    = 38;
		res_ack = 1'b0;
		forever begin
			@(negedge clk);
			if (res_req && !res_ack) begin
				wait_cycles = $unsigned($random(seed)) % 5;
				repeat (wait_cycles) @(negedge clk);
				res_ack = 1'b1;
			end else if (!res_req && res_ack) begin
				res_ack = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
			$display("timeout: the run did not finish within %0d cycles", timeout_limit);
			$display("Checks failed");
			$finish;
		end
	end

	initial begin
		clk          = 1'b0;
		reset        = 1'b1;
		sub_req      = 1'b0;
		sub_data     = '0;
		cfg_req      = 1'b0;
		cfg_data     = '0;
		test_end     = 1'b0;
		test_id      = '0;
		test_results = 0;
		load_table();
		timeout_limit = rows.size() * 60;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < rows.size(); i++) begin
			case (rows[i].kind)
				K_CFG:   send_cfg(rows[i]);
				K_SUB:   send_submit(rows[i]);
				default: drain_results();
			endcase
			if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test)
				finish_test(rows[i]);
		end
		$display("closing counts: %0d results, %0d errors, %0d assertion failures",
			result_count, error_count, DUT.u_assertions.failures);
		if (error_count == 0 && DUT.u_assertions.failures == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
common/fpc_pkg.sv
logic/fprint_ram.sv
logic/fprint_capture.sv
comp_registers/comp_registers.sv
logic/fprint_comparator.sv
logic/fpc_top.sv
verification/fpc_assertions.sv
verification/fpc_checker.sv
verification/fpc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 --top-module fpc_tb -f vlog.f -o fpc_sim

status=0
./obj_dir/fpc_sim +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
	echo "simulation reported failing checks"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi
echo "simulation finished without failures"
